//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_pipe
FILELIST  ?= rv_pipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- rv_decode.sv
// rv decode stage
// splits the instruction word, builds immediates and ALU/branch control,
// then registers it all into the decode/execute register

`include "rv_pipe_cfg.svh"

module rv_decode
  import rv_pipe_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               f_valid,
  input  logic [`XLEN-1:0]   f_pc,
  input  logic [`XLEN-1:0]   f_inst,
  output logic [`REG_AW-1:0] rs1,
  output logic [`REG_AW-1:0] rs2,
  input  logic [`XLEN-1:0]   rdata1,
  input  logic [`XLEN-1:0]   rdata2,
  output logic               d_valid,
  output logic [`XLEN-1:0]   d_pc,
  output logic [`REG_AW-1:0] d_rd,
  output logic [`REG_AW-1:0] d_rs1,
  output logic [`REG_AW-1:0] d_rs2,
  output logic [`XLEN-1:0]   d_op1,
  output logic [`XLEN-1:0]   d_op2,
  output logic [`XLEN-1:0]   d_imm,
  output alu_op_e            d_alu_op,
  output logic               d_use_imm,
  output br_cond_e           d_br_cond,
  output logic               d_wr
);

  inst_u            inst;
  logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_sh;
  logic [`XLEN-1:0] imm;
  logic             known, use_imm, wr;
  alu_op_e          alu_op;
  br_cond_e         br_cond;

  // funct3 map shared by OP and OP-IMM, alt selects sub / sra
  function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign inst = f_inst;
  assign rs1  = inst.r_fmt.rs1;
  assign rs2  = inst.r_fmt.rs2;

  assign imm_i  = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
  assign imm_b  = {{(`XLEN-12){inst.b_fmt.imm_hi[6]}}, inst.b_fmt.imm_lo[0],
                   inst.b_fmt.imm_hi[5:0], inst.b_fmt.imm_lo[4:1], 1'b0};
  assign imm_u  = {inst.u_fmt.imm20, 12'b0};
  assign imm_sh = {{(`XLEN-5){1'b0}}, inst.i_fmt.imm12[4:0]};  // shamt

  always_comb
  begin
    known   = 1'b0;
    wr      = 1'b0;
    use_imm = 1'b0;
    imm     = imm_i;
    alu_op  = ALU_ADD;
    br_cond = BR_NONE;
    case (inst.r_fmt.opcode)
      `OPC_OP:
      begin
        known  = 1'b1;
        wr     = 1'b1;
        alu_op = alu_from_funct3(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
      end
      `OPC_IMM:
      begin
        known   = 1'b1;
        wr      = 1'b1;
        use_imm = 1'b1;
        // no subi, bit 30 only matters for the right shift
        alu_op  = alu_from_funct3(inst.i_fmt.funct3,
                                  inst.i_fmt.funct3 == 3'b101 && inst.r_fmt.funct7[5]);
        if (inst.i_fmt.funct3 == 3'b001 || inst.i_fmt.funct3 == 3'b101)
          imm = imm_sh;
      end
      `OPC_LUI:
      begin
        known   = 1'b1;
        wr      = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
      end
      `OPC_BRANCH:
      begin
        imm   = imm_b;
        known = 1'b1;
        case (inst.b_fmt.funct3)
          3'b000:  br_cond = BR_EQ;
          3'b001:  br_cond = BR_NE;
          3'b100:  br_cond = BR_LT;
          3'b101:  br_cond = BR_GE;
          3'b110:  br_cond = BR_LTU;
          3'b111:  br_cond = BR_GEU;
          default: known   = 1'b0;   // 010 and 011 are not branches
        endcase
      end
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      d_valid <= 1'b0;
    else
      d_valid <= f_valid && known && !flush;  // unknown opcode becomes a bubble
  end

  always_ff @(posedge clk)
  begin
    d_pc      <= f_pc;
    d_rd      <= inst.r_fmt.rd;
    d_rs1     <= inst.r_fmt.rs1;
    d_rs2     <= inst.r_fmt.rs2;
    d_op1     <= rdata1;
    d_op2     <= rdata2;
    d_imm     <= imm;
    d_alu_op  <= alu_op;
    d_use_imm <= use_imm;
    d_br_cond <= br_cond;
    d_wr      <= wr;
  end

endmodule

//--- rv_execute.sv
// rv execute stage
// forwarding from writeback, ALU, branch resolve and redirect

`include "rv_pipe_cfg.svh"

module rv_execute
  import rv_pipe_pkg::*;
(
  input  logic               d_valid,
  input  logic [`XLEN-1:0]   d_pc,
  input  logic [`REG_AW-1:0] d_rd,
  input  logic [`REG_AW-1:0] d_rs1,
  input  logic [`REG_AW-1:0] d_rs2,
  input  logic [`XLEN-1:0]   d_op1,
  input  logic [`XLEN-1:0]   d_op2,
  input  logic [`XLEN-1:0]   d_imm,
  input  alu_op_e            d_alu_op,
  input  logic               d_use_imm,
  input  br_cond_e           d_br_cond,
  input  logic               d_wr,
  input  logic               wb_valid,
  input  logic [`REG_AW-1:0] wb_rd,
  input  logic [`XLEN-1:0]   wb_data,
  output logic               e_valid,
  output logic [`REG_AW-1:0] e_rd,
  output logic [`XLEN-1:0]   e_data,
  output logic               redirect,
  output logic [`XLEN-1:0]   redirect_pc
);

  logic [`XLEN-1:0] src_a;    // rs1 after forwarding
  logic [`XLEN-1:0] src_b;    // rs2 after forwarding
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_out;
  logic [4:0]       shamt;
  logic             lt_s, lt_u, eq;
  logic             taken;

  // wb_valid is never set for x0, so no rd check needed here
  assign src_a = (wb_valid && wb_rd == d_rs1) ? wb_data : d_op1;
  assign src_b = (wb_valid && wb_rd == d_rs2) ? wb_data : d_op2;

  assign alu_b = d_use_imm ? d_imm : src_b;
  assign shamt = alu_b[4:0];

  always_comb
  begin
    case (d_alu_op)
      ALU_ADD:    alu_out = src_a + alu_b;
      ALU_SUB:    alu_out = src_a - alu_b;
      ALU_SLL:    alu_out = src_a << shamt;
      ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
      ALU_SLTU:   alu_out = {{(`XLEN-1){1'b0}}, src_a < alu_b};
      ALU_XOR:    alu_out = src_a ^ alu_b;
      ALU_SRL:    alu_out = src_a >> shamt;
      ALU_SRA:    alu_out = $signed(src_a) >>> shamt;  // keeps the sign bit
      ALU_OR:     alu_out = src_a | alu_b;
      ALU_AND:    alu_out = src_a & alu_b;
      ALU_PASS_B: alu_out = alu_b;                     // lui
      default:    alu_out = '0;
    endcase
  end

  // branch compare always on the two registers
  assign eq   = (src_a == src_b);
  assign lt_s = ($signed(src_a) < $signed(src_b));
  assign lt_u = (src_a < src_b);

  always_comb
  begin
    case (d_br_cond)
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt_s;
      BR_GE:   taken = !lt_s;
      BR_LTU:  taken = lt_u;
      BR_GEU:  taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  // predicted not taken, so only a taken branch redirects
  assign redirect    = d_valid && taken;
  assign redirect_pc = d_pc + d_imm;

  // branches come with d_wr low
  assign e_valid = d_valid && d_wr && (d_rd != '0);
  assign e_rd    = d_rd;
  assign e_data  = alu_out;

endmodule

//--- rv_fetch.sv
// rv fetch stage
// program counter, fetch/decode register, branch redirect and stop on a zero word

`include "rv_pipe_cfg.svh"

module rv_fetch (
  input  logic              clk,
  input  logic              rst,
  input  logic [`XLEN-1:0]  inst_word,
  input  logic              redirect,
  input  logic [`XLEN-1:0]  redirect_pc,
  output logic [`XLEN-1:0]  inst_addr,
  output logic              f_valid,
  output logic [`XLEN-1:0]  f_pc,
  output logic [`XLEN-1:0]  f_inst,
  output logic              fetch_stopped
);

  logic [`XLEN-1:0] pc;
  logic             zero_word;

  assign inst_addr = pc;
  assign zero_word = (inst_word == '0);

  // pc, predicted not taken
  always_ff @(posedge clk)
  begin
    if (rst)
      pc <= `RESET_PC;
    else if (redirect)
      pc <= redirect_pc;             // taken branch wins over everything
    else if (!fetch_stopped && !zero_word)
      pc <= pc + 4;
  end

  // once the last word is seen fetch stays stopped until reset
  always_ff @(posedge clk)
  begin
    if (rst)
      fetch_stopped <= 1'b0;
    else if (!redirect && zero_word)
      fetch_stopped <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      f_valid <= 1'b0;
    else
      f_valid <= !redirect && !fetch_stopped && !zero_word;
  end

  always_ff @(posedge clk)
  begin
    f_pc   <= pc;
    f_inst <= inst_word;
  end

endmodule

//--- rv_pipe.f
+incdir+.
rv_pipe_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_regfile.sv
rv_pipe_top.sv
rv_pipe_assertions.sv
tb_rv_pipe.sv

//--- rv_pipe_assertions.sv
// rv pipe assertions
// concurrent checks on the top-level ports, bound into rv_pipe_top

`include "rv_pipe_cfg.svh"

module rv_pipe_assertions (
  input logic               clk,
  input logic               rst,
  input logic [`XLEN-1:0]   inst_addr,
  input logic               retire_valid,
  input logic [`REG_AW-1:0] retire_rd,
  input logic               halt
);

  // only reset may clear halt
  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without reset");

  retire_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire_rd != '0)
    else $error("retire to x0");

  inst_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    inst_addr[1:0] == 2'b00)
    else $error("inst_addr not word aligned");

endmodule

bind rv_pipe_top rv_pipe_assertions u_assertions (
  .clk, .rst, .inst_addr, .retire_valid, .retire_rd, .halt
);

//--- rv_pipe_cfg.svh
// rv pipe configuration
// widths, reset address and the RV32I opcodes the pipeline runs

`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// data and address width
`define XLEN      32

// architectural registers
`define REG_COUNT 32
`define REG_AW    5

`define RESET_PC  32'h0000_0000

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_IMM    7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011

`endif

//--- rv_pipe_pkg.sv
// rv pipe types
// instruction word views, ALU operations and branch conditions

`include "rv_pipe_cfg.svh"

package rv_pipe_pkg;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm12;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]         imm_hi;  // imm[12], imm[10:5]
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_lo;  // imm[4:1], imm[11]
    logic [6:0]         opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]        imm20;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } u_fmt_t;

  // one instruction word, four ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_cond_e;

endpackage

//--- rv_pipe_top.sv
// rv pipe top
// four-stage RV32I integer pipeline: fetch, decode, execute, writeback

`include "rv_pipe_cfg.svh"

module rv_pipe_top
  import rv_pipe_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  output logic [`XLEN-1:0]   inst_addr,
  input  logic [`XLEN-1:0]   inst_word,
  output logic               retire_valid,
  output logic [`REG_AW-1:0] retire_rd,
  output logic [`XLEN-1:0]   retire_data,
  output logic               halt
);

  logic               f_valid, fetch_stopped;
  logic [`XLEN-1:0]   f_pc, f_inst;
  logic [`REG_AW-1:0] rs1, rs2;
  logic [`XLEN-1:0]   rdata1, rdata2;
  logic               d_valid, d_use_imm, d_wr;
  logic [`XLEN-1:0]   d_pc, d_op1, d_op2, d_imm;
  logic [`REG_AW-1:0] d_rd, d_rs1, d_rs2;
  alu_op_e            d_alu_op;
  br_cond_e           d_br_cond;
  logic               e_valid, redirect;
  logic [`REG_AW-1:0] e_rd;
  logic [`XLEN-1:0]   e_data, redirect_pc;

  rv_fetch u_fetch (
    .clk, .rst, .inst_word, .redirect, .redirect_pc, .inst_addr,
    .f_valid, .f_pc, .f_inst, .fetch_stopped
  );

  rv_decode u_decode (
    .clk, .rst, .flush(redirect), .f_valid, .f_pc, .f_inst, .rs1, .rs2, .rdata1, .rdata2,
    .d_valid, .d_pc, .d_rd, .d_rs1, .d_rs2, .d_op1, .d_op2, .d_imm, .d_alu_op,
    .d_use_imm, .d_br_cond, .d_wr
  );

  rv_execute u_execute (
    .d_valid, .d_pc, .d_rd, .d_rs1, .d_rs2, .d_op1, .d_op2, .d_imm, .d_alu_op,
    .d_use_imm, .d_br_cond, .d_wr,
    .wb_valid(retire_valid), .wb_rd(retire_rd), .wb_data(retire_data),  // forward path
    .e_valid, .e_rd, .e_data, .redirect, .redirect_pc
  );

  rv_regfile u_regfile (
    .clk, .rst, .rs1, .rs2, .rdata1, .rdata2, .e_valid, .e_rd, .e_data,
    .retire_valid, .retire_rd, .retire_data
  );

  // sticky once fetch has stopped and the pipe has drained
  always_ff @(posedge clk)
  begin
    if (rst)
      halt <= 1'b0;
    else if (fetch_stopped && !f_valid && !d_valid && !retire_valid)
      halt <= 1'b1;
  end

endmodule

//--- rv_regfile.sv
// rv register file
// writeback register driving the retire port, 32 x XLEN array with write bypass

`include "rv_pipe_cfg.svh"

module rv_regfile (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] rs1,
  input  logic [`REG_AW-1:0] rs2,
  output logic [`XLEN-1:0]   rdata1,
  output logic [`XLEN-1:0]   rdata2,
  input  logic               e_valid,
  input  logic [`REG_AW-1:0] e_rd,
  input  logic [`XLEN-1:0]   e_data,
  output logic               retire_valid,
  output logic [`REG_AW-1:0] retire_rd,
  output logic [`XLEN-1:0]   retire_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // writeback stage
  always_ff @(posedge clk)
  begin
    if (rst)
      retire_valid <= 1'b0;
    else
      retire_valid <= e_valid;
  end

  always_ff @(posedge clk)
  begin
    retire_rd   <= e_rd;
    retire_data <= e_data;
  end

  always_ff @(posedge clk)
  begin
    if (retire_valid)
      regs[retire_rd] <= retire_data;
  end

  // x0 reads zero, a register being written this cycle reads the new value
  assign rdata1 = (rs1 == '0) ? '0 :
                  (retire_valid && retire_rd == rs1) ? retire_data : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 :
                  (retire_valid && retire_rd == rs2) ? retire_data : regs[rs2];

endmodule

//--- tb_rv_pipe.sv
// tb_rv_pipe
// testbench for the four-stage RV32I pipeline: instruction memory model,
// program table with expected retires, in-order retire checker and watchdog

`include "rv_pipe_cfg.svh"

module tb_rv_pipe;

  logic               clk = 1'b0;
  logic               rst;
  logic [`XLEN-1:0]   inst_addr;
  logic [`XLEN-1:0]   inst_word;
  logic               retire_valid;
  logic [`REG_AW-1:0] retire_rd;
  logic [`XLEN-1:0]   retire_data;
  logic               halt;

  // program table, one entry per instruction word
  logic [31:0] tbl_word [256];
  bit          tbl_ret  [256];
  logic [4:0]  tbl_rd   [256];
  logic [31:0] tbl_val  [256];
  int          n_entries = 0;

  logic [4:0]  exp_rd  [256];     // retires in program order
  logic [31:0] exp_val [256];
  int          exp_count = 0;
  int          chk_idx = 0;       // retires seen so far
  int          value_errors = 0;
  int          order_errors = 0;
  int          end_errors = 0;
  logic [31:0] shadow [32];       // register values the program should leave
  logic [31:0] lcg_state = 32'h146de3b1;
  logic [31:0] word_idx;

  rv_pipe_top dut (
    .clk, .rst, .inst_addr, .inst_word, .retire_valid, .retire_rd, .retire_data, .halt
  );

  always #5 clk = ~clk;

  // combinational instruction memory, past the end reads zero
  assign word_idx  = inst_addr >> 2;
  assign inst_word = (word_idx < n_entries) ? tbl_word[word_idx[7:0]] : '0;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] op_r(input int f3, input int f7, input int rd,
                                       input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
  endfunction

  function automatic logic [31:0] op_i(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_IMM};
  endfunction

  function automatic logic [31:0] op_lui(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], `OPC_LUI};
  endfunction

  function automatic logic [31:0] op_b(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OPC_BRANCH};
  endfunction

  task automatic add_entry(input logic [31:0] word, input int retires, input int rd,
                           input logic [31:0] value);
    tbl_word[n_entries[7:0]] = word;
    tbl_ret[n_entries[7:0]]  = (retires != 0);
    tbl_rd[n_entries[7:0]]   = rd[4:0];
    tbl_val[n_entries[7:0]]  = value;
    if (retires != 0)
      shadow[rd[4:0]] = value;
    n_entries++;
  endtask

  // branch to pc+12, the two words in between must never retire
  task automatic add_taken_branch(input int f3, input int rs1, input int rs2);
    add_entry(op_b(f3, rs1, rs2, 12), 0, 0, '0);
    add_entry(op_i(0, 25, 0, 111), 0, 0, '0);
    add_entry(op_i(0, 25, 0, 222), 0, 0, '0);
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] imm32;
    int          rd;
    int          src;
    shadow[0] = '0;
    add_entry(op_i(0, 1, 0, 100), 1, 1, 32'h0000_0064);
    add_entry(op_i(0, 7, 0, 3), 1, 7, 32'h0000_0003);
    add_entry(op_i(0, 2, 0, -7), 1, 2, 32'hFFFF_FFF9);
    add_entry(op_lui(3, 'h80000), 1, 3, 32'h8000_0000);
    add_entry(op_r(0, 0, 4, 1, 2), 1, 4, 32'h0000_005D);         // x2 at distance 2
    add_entry(op_r(0, 'h20, 5, 4, 1), 1, 5, 32'hFFFF_FFF9);      // sub, x4 at distance 1
    add_entry(op_r(1, 0, 6, 1, 7), 1, 6, 32'h0000_0320);
    add_entry(op_r(2, 0, 8, 2, 1), 1, 8, 32'h0000_0001);
    add_entry(op_r(3, 0, 9, 2, 1), 1, 9, 32'h0000_0000);
    add_entry(op_r(4, 0, 10, 1, 2), 1, 10, 32'hFFFF_FF9D);
    add_entry(op_r(5, 0, 11, 2, 7), 1, 11, 32'h1FFF_FFFF);
    add_entry(op_r(5, 'h20, 12, 2, 7), 1, 12, 32'hFFFF_FFFF);
    add_entry(op_r(6, 0, 13, 1, 7), 1, 13, 32'h0000_0067);
    add_entry(op_r(7, 0, 14, 1, 2), 1, 14, 32'h0000_0060);
    add_entry(op_i(1, 15, 1, 4), 1, 15, 32'h0000_0640);
    add_entry(op_i(5, 16, 2, 28), 1, 16, 32'h0000_000F);
    add_entry(op_i(5, 17, 2, 'h401), 1, 17, 32'hFFFF_FFFC);      // srai of a negative value
    add_entry(op_i(2, 18, 2, -6), 1, 18, 32'h0000_0001);
    add_entry(op_i(3, 19, 1, 99), 1, 19, 32'h0000_0000);
    add_entry(op_i(6, 20, 1, 'hF0), 1, 20, 32'h0000_00F4);
    add_entry(op_i(7, 21, 2, 'hFF), 1, 21, 32'h0000_00F9);
    add_entry(op_i(4, 22, 1, -1), 1, 22, 32'hFFFF_FF9B);
    add_entry(op_lui(23, 'h12345), 1, 23, 32'h1234_5000);
    add_entry(op_i(0, 23, 23, 'h678), 1, 23, 32'h1234_5678);
    add_entry(op_r(0, 0, 0, 1, 1), 0, 0, '0);                    // write to x0, no retire
    add_entry(op_r(0, 0, 24, 0, 1), 1, 24, 32'h0000_0064);
    add_taken_branch(0, 1, 24);
    add_taken_branch(1, 1, 2);
    add_taken_branch(4, 2, 1);
    add_taken_branch(5, 1, 2);
    add_taken_branch(6, 1, 2);
    add_taken_branch(7, 2, 1);
    add_entry(op_b(0, 1, 2, 12), 0, 0, '0);                      // untaken beq
    add_entry(op_i(0, 25, 0, 5), 1, 25, 32'h0000_0005);
    add_entry(op_b(7, 1, 2, 12), 0, 0, '0);                      // untaken bgeu
    add_entry(op_i(0, 26, 25, 1), 1, 26, 32'h0000_0006);
    add_entry(op_b(4, 1, 2, 12), 0, 0, '0);                      // untaken blt
    add_entry(op_r(0, 0, 27, 26, 25), 1, 27, 32'h0000_000B);
    add_taken_branch(1, 27, 24);   // compare operand comes from writeback
    // chain of random addi / xori, each one using the previous result
    src = 1;
    for (int k = 0; k < 16; k++)
    begin
      r     = next_rand();
      imm32 = {{20{r[27]}}, r[27:16]};
      rd    = 28 + k % 4;
      if (r[5])
        add_entry(op_i(4, rd, src, imm32), 1, rd, shadow[src[4:0]] ^ imm32);
      else
        add_entry(op_i(0, rd, src, imm32), 1, rd, shadow[src[4:0]] + imm32);
      src = rd;
    end
  endtask

  // in-order retire checker
  always @(posedge clk)
  begin
    if (!rst && retire_valid)
    begin
      assert (!halt)
      else
      begin
        order_errors++;
        $display("retire to x%0d at time %0t while halt is already high", retire_rd, $time);
      end
      assert (chk_idx < exp_count)
      else
      begin
        order_errors++;
        $display("retire to x%0d at time %0t with no retire left to expect", retire_rd, $time);
      end
      if (chk_idx < exp_count)
      begin
        assert (retire_rd == exp_rd[chk_idx[7:0]])
        else
        begin
          value_errors++;
          $display("ERROR time %0t: retire_rd expected %0d, got %0d",
                   $time, exp_rd[chk_idx[7:0]], retire_rd);
        end
        assert (retire_data == exp_val[chk_idx[7:0]])
        else
        begin
          value_errors++;
          $display("ERROR time %0t: retire_data expected %h, got %h",
                   $time, exp_val[chk_idx[7:0]], retire_data);
        end
      end
      chk_idx++;
    end
  end

  initial
  begin
    rst = 1'b1;
    build_program();
    for (int i = 0; i < n_entries; i++)
    begin
      if (tbl_ret[i[7:0]])
      begin
        exp_rd[exp_count[7:0]]  = tbl_rd[i[7:0]];
        exp_val[exp_count[7:0]] = tbl_val[i[7:0]];
        exp_count++;
      end
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (!halt)
      @(posedge clk);
    repeat (5) @(posedge clk);     // a late retire would still be caught here
    assert (chk_idx == exp_count)
    else
    begin
      end_errors++;
      $display("program ended with %0d retires instead of %0d", chk_idx, exp_count);
    end
    $display("errors: %0d value, %0d order, %0d end of run",
             value_errors, order_errors, end_errors);
    if (value_errors + order_errors + end_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #1;
    repeat (20 * n_entries + 100) @(posedge clk);
    $display("timeout: halt did not rise within %0d cycles", 20 * n_entries + 100);
    $display("Simulation failed");
    $finish;
  end

endmodule
